/* Bender.yml */
package:
  name: uc_core

sources:
  - src/uc_pkg.sv
  - src/opcode_fetch.sv
  - src/irq_prio.sv
  - src/useq.sv
  - src/urom.sv
  - src/uc_top.sv
  - target: test
    files:
      - tests/uc_props.sv
      - tests/uc_tb.sv

/* filelist.f */
src/uc_pkg.sv
src/opcode_fetch.sv
src/irq_prio.sv
src/useq.sv
src/urom.sv
src/uc_top.sv
tests/uc_props.sv
tests/uc_tb.sv

/* src/irq_prio.sv */
// **************************************
// interrupt priority encoder
// nmi edge latch, mask on maskable lines
// vector code of the winning request
// **************************************
`timescale 1ns/1ps

module irq_prio
    import uc_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  i,        // interrupt mask, from cc register
    input  logic  nmi,
    input  logic  irq,
    input  logic  irq_tmr,
    input  logic  irq2,
    input  logic  irq_sci,
    input  logic  irq_take,
    output logic  irq_valid,
    output ivec_t irq_vec
);

logic nmi_q;     // registered nmi
logic nmi_flag;  // pending edge
logic nmi_edge;
logic mask_any;  // some maskable line open and high

assign nmi_edge = nmi & ~nmi_q;
assign mask_any = ~i & (irq | irq_tmr | irq2 | irq_sci);

always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
        nmi_q    <= 1'b0;
        nmi_flag <= 1'b0;
    end else begin
        nmi_q <= nmi;
        if (irq_take) nmi_flag <= 1'b0; // serviced
        if (nmi_edge) nmi_flag <= 1'b1; // a fresh edge wins over the clear
    end
end

assign irq_valid = nmi_flag | mask_any;

// highest first: nmi, irq, tmr, irq2, sci
always_comb begin
    if (nmi_flag)          irq_vec = IV_NMI;
    else if (~i & irq)     irq_vec = IV_IRQ;
    else if (~i & irq_tmr) irq_vec = IV_TMR;
    else if (~i & irq2)    irq_vec = IV_IRQ2;
    else                   irq_vec = IV_SCI; // also the don't-care case
end

endmodule

/* src/opcode_fetch.sv */
// **************************************
// opcode fetch unit
// wishbone classic read master
// program counter and one-entry opcode buffer
// **************************************
`timescale 1ns/1ps

module opcode_fetch
    import uc_pkg::*;
#(
    parameter logic [15:0] RESET_PC = 16'h0000
) (
    input  logic       clk,
    input  logic       rst,
    output wb_m2s_t    wb_o,
    input  wb_s2m_t    wb_i,
    output logic [7:0] op,
    output logic       op_valid,
    input  logic       op_take
);

logic [15:0] pc;
logic        cyc_q;   // read in flight
logic        full;    // buffer holds an opcode

// bus side comes straight from the registers
// pc only moves on ack, so adr is stable for the whole read
always_comb begin
    wb_o.cyc = cyc_q;
    wb_o.stb = cyc_q;
    wb_o.we  = 1'b0;  // reads only
    wb_o.adr = pc;
end

assign op_valid = full;

always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
        pc    <= RESET_PC;
        cyc_q <= 1'b0;
        full  <= 1'b0;
    end else begin
        if (op_take) full <= 1'b0; // consumer emptied it
        if (cyc_q) begin
            if (wb_i.ack) begin
                cyc_q <= 1'b0;          // drop cyc/stb, idle cycle follows
                full  <= 1'b1;
                pc    <= pc + 16'd1;
            end
            // no ack, hold everything
        end else if (!full || op_take) begin
            cyc_q <= 1'b1;              // buffer empty, start a read
        end
    end
end

// payload only, captured with the ack
always_ff @(posedge clk) begin
    if (cyc_q && wb_i.ack) op <= wb_i.dat;
end

endmodule

/* src/uc_pkg.sv */
// **************************************
// shared types of the microcoded control
// micro-address and fixed slot numbers
// control word, jump word and their union
// interrupt vector codes
// wishbone master and slave bundles
// **************************************
package uc_pkg;

    // upper 8 bits opcode or slot, lower 4 bits step
    typedef logic [11:0] uaddr_t;

    localparam uaddr_t IVRD   = 12'h000; // reset slot
    localparam uaddr_t INTSRV = 12'hc70; // interrupt service slot
    localparam uaddr_t SUBR   = 12'hf00; // shared micro-subroutine

    // control view of the rom word, msb first
    typedef struct packed {
        logic       jsr;      // set selects the jump view
        logic       ni;       // next-instruction point
        logic       alu16;
        logic       wr;
        logic [1:0] opnd_sel;
        logic [1:0] ea_sel;
        logic [3:0] ld_sel;
        logic [3:0] alu_sel;
    } ctrl_t;

    // jump view, jsr sits at bit 15 as in ctrl_t
    typedef struct packed {
        logic       jsr;
        logic [1:0] spare;
        logic       ret;      // return to the saved step
        uaddr_t     target;
    } jump_t;

    typedef union packed {
        ctrl_t c;
        jump_t j;
    } uword_t;

    typedef logic [3:0] ivec_t;

    localparam ivec_t IV_RESET = 4'o17;
    localparam ivec_t IV_NMI   = 4'o16;
    localparam ivec_t IV_IRQ   = 4'o14;
    localparam ivec_t IV_TMR   = 4'o11;
    localparam ivec_t IV_IRQ2  = 4'o05;
    localparam ivec_t IV_SCI   = 4'o10;

    // driven by the master
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [15:0] adr;
    } wb_m2s_t;

    // returned by the slave
    typedef struct packed {
        logic [7:0] dat;
        logic       ack;
    } wb_s2m_t;

endpackage

/* src/uc_top.sv */
// **************************************
// control section top level
// fetch, irq priority, sequencer, rom
// ctrl forced to zero on jump words
// **************************************
`timescale 1ns/1ps

module uc_top
    import uc_pkg::*;
#(
    parameter logic [15:0] RESET_PC = 16'h0100
) (
    input  logic    clk,
    input  logic    rst,
    output wb_m2s_t wb_o,
    input  wb_s2m_t wb_i,
    input  logic    i,
    input  logic    nmi,
    input  logic    irq,
    input  logic    irq_tmr,
    input  logic    irq2,
    input  logic    irq_sci,
    input  logic    ext_halt,
    output logic    ba,
    output ivec_t   iv,
    output ctrl_t   ctrl
);

logic [7:0] op;
logic       op_valid, op_take;
logic       irq_valid, irq_take;
ivec_t      irq_vec;
uaddr_t     uaddr;
uword_t     uword;

opcode_fetch #(.RESET_PC(RESET_PC)) u_fetch (
    .clk, .rst, .wb_o, .wb_i, .op, .op_valid, .op_take
);

irq_prio u_irq (
    .clk, .rst, .i, .nmi, .irq, .irq_tmr, .irq2, .irq_sci,
    .irq_take, .irq_valid, .irq_vec
);

useq u_useq (
    .clk, .rst, .uword, .uaddr, .op, .op_valid, .op_take,
    .irq_valid, .irq_vec, .irq_take, .ext_halt, .ba, .iv
);

urom u_urom (.uaddr, .uword);

assign ctrl = uword.c.jsr ? '0 : uword.c; // jump words carry no control

endmodule

/* src/urom.sv */
// **************************************
// microcode rom, combinational
// opcode slots built from the opcode bits
// fixed reset, service and subroutine slots
// **************************************
`timescale 1ns/1ps

module urom
    import uc_pkg::*;
(
    input  uaddr_t uaddr,
    output uword_t uword
);

logic [7:0] o;     // opcode / slot number
logic [3:0] k;     // step within slot
logic [3:0] last;  // last step of an opcode slot

assign o    = uaddr[11:4];
assign k    = uaddr[3:0];
assign last = {2'b00, o[1:0]} + {3'b000, o[7]}; // one step later behind the call

// the fixed slots shadow opcodes 00, c7 and f0
always_comb begin
    uword = '0; // unused steps are plain zero words
    if (o == IVRD[11:4] || o == INTSRV[11:4]) begin
        // reset and service slots, one word each
        if (k == 4'd0) begin
            uword.c.ld_sel = 4'he;
            uword.c.ni     = 1'b1;
        end
    end else if (o == SUBR[11:4]) begin
        if (k < 4'd2) begin
            uword.c.ld_sel = 4'hf;  // two body words
        end else if (k == 4'd2) begin
            uword.j.jsr = 1'b1;     // ret
            uword.j.ret = 1'b1;
        end
    end else if (o[7] && k == 4'd0) begin
        // call the shared subroutine first
        uword.j.jsr    = 1'b1;
        uword.j.target = SUBR;
    end else if (k <= last) begin
        uword.c.alu_sel = o[3:0];
        uword.c.ld_sel  = o[7] ? k - 4'd1 : k; // keeps the non-jump count
        uword.c.ni      = (k == last);
    end
end

endmodule

/* src/useq.sv */
// **************************************
// micro-sequencer
// step, jump, one-level call and return
// dispatch, interrupt diversion, bus grant
// **************************************
`timescale 1ns/1ps

module useq
    import uc_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  uword_t     uword,
    output uaddr_t     uaddr,
    input  logic [7:0] op,
    input  logic       op_valid,
    output logic       op_take,
    input  logic       irq_valid,
    input  ivec_t      irq_vec,
    output logic       irq_take,
    input  logic       ext_halt,
    output logic       ba,
    output ivec_t      iv
);

uaddr_t ret_q;     // one-deep return register
uaddr_t nx_step;   // next step in the same slot
logic   is_jump;
logic   ni;        // next-instruction point, control view only
logic   halt_now;  // ni point with halt requested
logic   go;        // ni point free to leave

assign is_jump  = uword.j.jsr;
assign ni       = ~is_jump & uword.c.ni;
assign halt_now = ni & ext_halt;
assign go       = ni & ~ext_halt;
assign nx_step  = {uaddr[11:4], uaddr[3:0] + 4'd1};

// handshakes in the cycle of the decision
// interrupt beats the opcode
assign irq_take = go & irq_valid;
assign op_take  = go & ~irq_valid & op_valid;

always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
        uaddr <= IVRD;
        ret_q <= IVRD;
        ba    <= 1'b0;
        iv    <= IV_RESET;
    end else begin
        ba <= halt_now; // falls on the edge after ext_halt drops
        if (is_jump) begin
            if (uword.j.ret) begin
                uaddr <= ret_q;         // back to the step after the call
            end else begin
                ret_q <= nx_step;       // every jump is a call
                uaddr <= uword.j.target;
            end
        end else if (ni) begin
            if (ext_halt) begin
                uaddr <= uaddr;         // hold, bus granted
            end else if (irq_valid) begin
                uaddr <= INTSRV;
                iv    <= irq_vec;       // latch winner for the service slot
            end else if (op_valid) begin
                uaddr <= {op, 4'h0};    // dispatch to opcode slot
            end
            // nothing ready, sit on the ni word
        end else begin
            uaddr <= nx_step;
        end
    end
end

endmodule

/* tests/uc_props.sv */
// **************************************
// bound checks for the control section
// reset, wishbone, dispatch, subroutine
// interrupt priority and bus grant
// **************************************
`timescale 1ns/1ps

module uc_props
    import uc_pkg::*;
#(
    parameter logic [15:0] RESET_PC = 16'h0000
) (
    input logic    clk,
    input logic    rst,
    input wb_m2s_t wb_o,
    input wb_s2m_t wb_i,
    input logic [7:0] op,
    input logic    op_take,
    input logic    irq_take,
    input logic    i,
    input logic    nmi,
    input logic    irq,
    input logic    irq_tmr,
    input logic    irq2,
    input logic    irq_sci,
    input logic    ext_halt,
    input logic    ba,
    input ivec_t   iv,
    input ctrl_t   ctrl,
    input uaddr_t  uaddr,
    input uword_t  uword
);

int          fail_cnt = 0;  // read by the testbench
logic [15:0] exp_adr;       // next read address
logic [7:0]  cur_op;        // opcode in execution
logic [3:0]  k_cnt;         // non-jump words seen in this instruction
logic        in_op;
logic        nmi_q, nmi_pend; // own model of the nmi edge
logic        exp_valid;
ivec_t       exp_vec;
logic        is_ctl, in_subr;

assign is_ctl    = ~uword.j.jsr;
assign in_subr   = uaddr[11:4] == SUBR[11:4];
assign exp_valid = nmi_pend | (~i & (irq | irq_tmr | irq2 | irq_sci));

always_comb begin
    exp_vec = IV_SCI; // lowest
    if (~i & irq2)    exp_vec = IV_IRQ2;
    if (~i & irq_tmr) exp_vec = IV_TMR;
    if (~i & irq)     exp_vec = IV_IRQ;
    if (nmi_pend)     exp_vec = IV_NMI;
end

always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
        exp_adr  <= RESET_PC;
        cur_op   <= '0;
        k_cnt    <= '0;
        in_op    <= 1'b0;
        nmi_q    <= 1'b0;
        nmi_pend <= 1'b0;
    end else begin
        nmi_q <= nmi;
        if (irq_take) nmi_pend <= 1'b0;
        if (nmi & ~nmi_q) nmi_pend <= 1'b1;
        if (wb_o.stb && wb_i.ack) exp_adr <= exp_adr + 16'd1;
        if (op_take) begin
            in_op  <= 1'b1;
            cur_op <= op;
            k_cnt  <= '0;
        end else if (in_op && is_ctl && !in_subr) begin
            if (!uword.c.ni) k_cnt <= k_cnt + 4'd1;
            else if (!ext_halt) in_op <= 1'b0; // instruction done
        end
    end
end

a_reset: assert property (@(posedge clk) disable iff (rst)
    $fell(rst) |-> iv == IV_RESET && !ba && !wb_o.cyc && !wb_o.stb && ctrl.ld_sel == 4'he)
    else begin fail_cnt++; $error("Fail reset state iv %h ld_sel %h", iv, ctrl.ld_sel); end

a_wb_hold: assert property (@(posedge clk) disable iff (rst)
    wb_o.stb && !wb_i.ack |=> wb_o.stb && $stable(wb_o.adr))
    else begin fail_cnt++; $error("Fail wb adr %h not held", wb_o.adr); end

a_wb_idle: assert property (@(posedge clk) disable iff (rst)
    wb_o.stb && wb_i.ack |=> !wb_o.stb)
    else begin fail_cnt++; $error("Fail wb stb high after ack"); end

a_wb_adr: assert property (@(posedge clk) disable iff (rst)
    wb_o.stb |-> wb_o.adr == exp_adr)
    else begin fail_cnt++; $error("Fail wb adr %h expected %h", wb_o.adr, exp_adr); end

// memory returns adr xor 5a
a_op: assert property (@(posedge clk) disable iff (rst)
    op_take |-> op == ((exp_adr[7:0] - 8'd1) ^ 8'h5a))
    else begin fail_cnt++; $error("Fail op %h", op); end

a_step: assert property (@(posedge clk) disable iff (rst)
    in_op && is_ctl && !in_subr |-> ctrl.alu_sel == cur_op[3:0]
        && ctrl.ld_sel == k_cnt && ctrl.ni == (k_cnt == {2'b00, cur_op[1:0]}))
    else begin fail_cnt++; $error("Fail ctrl %h op %h step %h", ctrl, cur_op, k_cnt); end

a_call: assert property (@(posedge clk) disable iff (rst)
    in_op && uaddr == {cur_op, 4'h0} |-> uword.j.jsr == cur_op[7])
    else begin fail_cnt++; $error("Fail jsr at slot of op %h", cur_op); end

a_subr: assert property (@(posedge clk) disable iff (rst)
    uword.j.jsr && !uword.j.ret |=> uaddr == SUBR && ctrl.ld_sel == 4'hf
        ##1 ctrl.ld_sel == 4'hf ##1 uword.j.jsr && uword.j.ret ##1 uaddr[3:0] == 4'h1)
    else begin fail_cnt++; $error("Fail subroutine at uaddr %h", uaddr); end

a_irq_ok: assert property (@(posedge clk) disable iff (rst)
    irq_take |-> exp_valid)
    else begin fail_cnt++; $error("Fail diversion with no request pending"); end

a_irq_vec: assert property (@(posedge clk) disable iff (rst)
    irq_take |=> uaddr == INTSRV && iv == $past(exp_vec))
    else begin fail_cnt++; $error("Fail iv %h expected %h", iv, $past(exp_vec)); end

a_halt: assert property (@(posedge clk) disable iff (rst)
    is_ctl && uword.c.ni && ext_halt |=> ba && uaddr == $past(uaddr))
    else begin fail_cnt++; $error("Fail halt ba %h uaddr %h", ba, uaddr); end

a_unhalt: assert property (@(posedge clk) disable iff (rst)
    ba && !ext_halt |=> !ba)
    else begin fail_cnt++; $error("Fail ba %h after halt release", ba); end

endmodule

bind uc_top uc_props #(.RESET_PC(RESET_PC)) u_props (
    .clk, .rst, .wb_o, .wb_i, .op, .op_take, .irq_take, .i, .nmi, .irq,
    .irq_tmr, .irq2, .irq_sci, .ext_halt, .ba, .iv, .ctrl, .uaddr, .uword
);

/* tests/uc_tb.sv */
// **************************************
// testbench of the control section
// clock, reset, lcg stimulus
// wishbone memory model with random ack delay
// error count and closing line
// **************************************
`timescale 1ns/1ps

module uc_tb
    import uc_pkg::*;
();

logic        clk, rst;
logic        i, nmi, irq, irq_tmr, irq2, irq_sci, ext_halt;
logic        ba;
ivec_t       iv;
ctrl_t       ctrl;
wb_m2s_t     wb_o;
wb_s2m_t     wb_i = '0;
logic        busy;      // memory counting down a read
logic [1:0]  dly;
int unsigned seed = 25;
int          timeouts = 0;
int          errors;

// start at e0 so the first opcodes have bit 7 set
// no fixed-slot opcode within the first 120 reads
uc_top #(.RESET_PC(16'h01e0)) u_uc_top (.*);

function automatic int unsigned lcg();
    seed = seed * 32'd1103515245 + 32'd12345;
    return (seed >> 16) & 32'h7fff;
endfunction

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

// memory model returns adr xor 5a after a random delay
always @(posedge clk) begin
    if (rst) begin
        busy     <= 1'b0;
        wb_i.ack <= 1'b0;
    end else begin
        wb_i.ack <= 1'b0;
        if (busy && dly == 2'd0) begin
            wb_i.ack <= 1'b1;
            wb_i.dat <= wb_o.adr[7:0] ^ 8'h5a;
            busy     <= 1'b0;
        end else if (busy) dly <= dly - 2'd1;
        else if (wb_o.stb && !wb_i.ack) begin
            busy <= 1'b1;
            dly  <= lcg() % 4;
        end
    end
end

task automatic wait_dispatch(input int n);
    int t;
    for (int d = 0; d < n; d++) begin
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!u_uc_top.op_take && t < 200);
        if (!u_uc_top.op_take) begin
            timeouts++;
            $display("timeout waiting for an opcode dispatch");
        end
    end
endtask

task automatic wait_irq_take();
    int t = 0;
    do begin
        @(negedge clk);
        t++;
    end while (!u_uc_top.irq_take && t < 100);
    if (!u_uc_top.irq_take) begin
        timeouts++;
        $display("timeout waiting for an interrupt diversion");
    end
endtask

task automatic wait_ba(input logic val);
    int t = 0;
    while (ba !== val && t < 100) begin
        @(negedge clk);
        t++;
    end
    if (ba !== val) begin
        timeouts++;
        $display("timeout waiting for bus grant to change");
    end
endtask

// short random pulses on interrupts and halt
task automatic run_random(input int n);
    repeat (n) begin
        @(posedge clk);
        nmi      <= (lcg() % 37) == 0;
        irq      <= (lcg() % 29) == 0;
        irq_tmr  <= (lcg() % 31) == 0;
        irq2     <= (lcg() % 27) == 0;
        irq_sci  <= (lcg() % 23) == 0;
        ext_halt <= (lcg() % 41) == 0;
    end
    @(posedge clk);
    {nmi, irq, irq_tmr, irq2, irq_sci, ext_halt} <= '0;
endtask

initial begin
    rst = 1'b1;
    i = 1'b1;
    {nmi, irq, irq_tmr, irq2, irq_sci, ext_halt} = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    wait_dispatch(10);
    @(posedge clk); // several maskable lines at once
    i <= 1'b0;
    {irq_tmr, irq2, irq_sci} <= 3'b111;
    wait_irq_take();
    @(posedge clk);
    {irq_tmr, irq2, irq_sci} <= 3'b000;
    i <= 1'b1;
    wait_dispatch(3);
    @(posedge clk); // masked irq held with a single nmi edge
    irq <= 1'b1;
    nmi <= 1'b1;
    wait_irq_take();
    @(posedge clk);
    nmi <= 1'b0;
    wait_dispatch(4);
    @(posedge clk);
    irq <= 1'b0;
    ext_halt <= 1'b1;
    wait_ba(1'b1);
    repeat (6) @(posedge clk);
    ext_halt <= 1'b0;
    wait_ba(1'b0);
    wait_dispatch(2);
    @(posedge clk);
    i <= 1'b0;
    run_random(200);
    wait_dispatch(3);
    errors = u_uc_top.u_props.fail_cnt + timeouts;
    $display("errors %0d, assertion failures %0d, timeouts %0d",
        errors, u_uc_top.u_props.fail_cnt, timeouts);
    if (errors == 0)
        $display("TESTBENCH PASSED");
    else
        $display("TESTBENCH FAILED");
    $finish;
end

endmodule
